// ==== include/mmio_config.svh ====
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// data memory window, byte addresses below the limit
`define MMIO_MEM_LIMIT      32'd2048
`define MMIO_MEM_WORDS      512         // 2 KiB of 32-bit words

// peripheral registers, decoded on the full byte address
`define MMIO_SPI_CMD_ADDR   32'd121212  // command + counter
`define MMIO_SPI_PARAM_ADDR 32'd333333  // parameters, launches a transfer
`define MMIO_I2C_ADDR       32'd923923  // touch coordinates, read only

// returned for unmapped reads and for i2c reads before done
`define MMIO_BAD_DATA       32'hDEADBEEF

`endif

// ==== hw/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

    typedef logic [31:0] addr_t;     // byte address from the memory handler
    typedef logic [31:0] data_t;
    typedef logic [8:0]  word_idx_t; // sram word index, byte address [10:2]

    // one request from the cpu memory handler
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  write;   // 0 = read
    } mmio_req_t;

    // response word, zero for writes
    typedef struct packed {
        data_t rdata;
    } mmio_rsp_t;

    // router -> wishbone master, full words only
    typedef struct packed {
        word_idx_t idx;
        data_t     wdata;
        logic      write;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    typedef logic [7:0]  spi_cmd_t;
    typedef logic [3:0]  spi_cnt_t;   // byte counter for the engine
    typedef logic [31:0] spi_par_t;
    typedef logic [31:0] i2c_xy_t;    // x in [31:16], y in [15:0]

    // held command register, written through the command address
    typedef struct packed {
        spi_cmd_t cmd;
        spi_cnt_t cnt;
    } spi_cmd_reg_t;

    // one complete transfer handed to the spi engine
    typedef struct packed {
        spi_cmd_t cmd;
        spi_cnt_t cnt;
        spi_par_t params;
    } spi_xfer_t;

endpackage

`default_nettype wire

// ==== hw/mmio_router.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mmio_config.svh"

module mmio_router (
    input  wire logic                    clk,
    input  wire logic                    rst_i,
    // request channel from the memory handler
    input  wire logic                    req_valid_i,
    input  wire mmio_pkg::mmio_req_t     req_i,
    output logic                         req_ready_o,
    // response channel back to it
    output logic                         rsp_valid_o,
    output mmio_pkg::mmio_rsp_t          rsp_o,
    input  wire logic                    rsp_ready_i,
    // i2c side, level inputs
    input  wire periph_pkg::i2c_xy_t     i2c_xy_i,
    input  wire logic                    i2c_done_i,
    // memory path
    output logic                         mem_valid_o,
    output mmio_pkg::mem_req_t           mem_req_o,
    input  wire logic                    mem_ready_i,
    input  wire logic                    mem_done_i,
    input  wire mmio_pkg::data_t         mem_rdata_i,
    // spi path
    output logic                         cmd_wr_o,
    output periph_pkg::spi_cmd_reg_t     cmd_o,
    output logic                         par_valid_o,
    output mmio_pkg::data_t              par_o,
    input  wire logic                    par_ready_i
);
    import mmio_pkg::*;
    import periph_pkg::*;

    typedef enum logic [2:0] {
        ROUTER_IDLE,    // waiting for a request
        MEM_ISSUE,      // offering the transfer to the wishbone master
        MEM_WAIT,       // cycle running, waiting for done
        SPI_WAIT,       // parameter write until the engine takes it
        RESP            // response held until rsp_ready_i
    } router_state_e;

    router_state_e state, state_nxt;

    mmio_req_t req_q;          // accepted request
    data_t     rsp_q;          // response word
    data_t     imm_rdata;      // single-cycle response, built at accept
    logic      accept;
    logic      hit_mem, hit_cmd, hit_par, hit_i2c;
    logic      mem_valid_q;
    logic      par_sent_q;     // parameters handed to the spi stage
    logic      cmd_wr_q;
    logic      mem_fwd;        // memory done, response straight from the master

    assign req_ready_o = (state == ROUTER_IDLE);
    assign accept      = req_valid_i && req_ready_o;

    // memory wins only inside its window, peripherals sit far above it
    always_comb begin
        hit_mem = (req_i.addr < `MMIO_MEM_LIMIT);
        hit_cmd = !hit_mem && (req_i.addr == `MMIO_SPI_CMD_ADDR);
        hit_par = !hit_mem && (req_i.addr == `MMIO_SPI_PARAM_ADDR);
        hit_i2c = !hit_mem && (req_i.addr == `MMIO_I2C_ADDR);
    end

    always_comb begin
        if (req_i.write) begin
            imm_rdata = '0;                     // writes answer zero
        end else if (hit_i2c && i2c_done_i) begin
            imm_rdata = i2c_xy_i;               // sampled at decode
        end else begin
            imm_rdata = `MMIO_BAD_DATA;         // unmapped, or i2c not ready
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ROUTER_IDLE: begin
                if (accept) begin
                    if (hit_mem) begin
                        state_nxt = MEM_ISSUE;
                    end else if (req_i.write && hit_par) begin
                        state_nxt = SPI_WAIT;
                    end else begin
                        state_nxt = RESP;       // cmd, i2c, unmapped
                    end
                end
            end
            MEM_ISSUE: if (mem_valid_q && mem_ready_i) state_nxt = MEM_WAIT;
            MEM_WAIT: begin
                if (mem_done_i) begin
                    state_nxt = rsp_ready_i ? ROUTER_IDLE : RESP;
                end
            end
            SPI_WAIT: if (par_sent_q && par_ready_i) state_nxt = RESP; // engine took it
            RESP:     if (rsp_ready_i) state_nxt = ROUTER_IDLE;
            default:  state_nxt = ROUTER_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= ROUTER_IDLE;
            mem_valid_q <= 1'b0;
            par_sent_q  <= 1'b0;
            cmd_wr_q    <= 1'b0;
        end else begin
            state    <= state_nxt;
            cmd_wr_q <= accept && req_i.write && hit_cmd;   // one-cycle pulse
            if (accept) begin
                mem_valid_q <= hit_mem;
                par_sent_q  <= 1'b0;
            end else begin
                if (mem_valid_q && mem_ready_i) mem_valid_q <= 1'b0;
                if (par_valid_o && par_ready_i) par_sent_q  <= 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
            rsp_q <= imm_rdata;
        end else if (mem_fwd) begin
            rsp_q <= mem_rdata_i;   // kept in case rsp_ready_i is low
        end
    end

    assign mem_fwd     = (state == MEM_WAIT) && mem_done_i;
    assign rsp_valid_o = (state == RESP) || mem_fwd;
    assign rsp_o       = '{rdata: mem_fwd ? mem_rdata_i : rsp_q};

    assign mem_valid_o = mem_valid_q;
    assign mem_req_o   = '{idx: req_q.addr[10:2], wdata: req_q.wdata, write: req_q.write};

    assign cmd_wr_o    = cmd_wr_q;
    assign cmd_o       = '{cmd: spi_cmd_t'(req_q.wdata[7:0]), cnt: spi_cnt_t'(req_q.wdata[11:8])};
    assign par_valid_o = (state == SPI_WAIT) && !par_sent_q;  // offered once
    assign par_o       = req_q.wdata;

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else $error("response changed under back-pressure");

    a_mem_valid_state: assert property (@(posedge clk) disable iff (rst_i)
        mem_valid_o |-> state == MEM_ISSUE)
        else $error("mem_valid_o outside MEM_ISSUE");

endmodule

`default_nettype wire

// ==== hw/wb_master.sv ====
`default_nettype none
`timescale 1ns/1ps

module wb_master (
    input  wire logic                clk,
    input  wire logic                rst_i,
    // transfer from the router
    input  wire logic                mem_valid_i,
    input  wire mmio_pkg::mem_req_t  mem_req_i,
    output logic                     mem_ready_o,
    output logic                     mem_done_o,
    output mmio_pkg::data_t          mem_rdata_o,
    // wishbone classic, full words only
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output mmio_pkg::word_idx_t      wb_adr_o,
    output mmio_pkg::data_t          wb_dat_o,
    input  wire mmio_pkg::data_t     wb_dat_i,
    input  wire logic                wb_ack_i
);
    import mmio_pkg::*;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_CYCLE,   // cyc/stb up, waiting for ack
        WB_DONE     // one-cycle done pulse
    } wb_state_e;

    wb_state_e state;
    word_idx_t adr_q;
    data_t     dat_q;
    data_t     rdata_q;
    logic      we_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= WB_IDLE;
        end else begin
            case (state)
                WB_IDLE:  if (mem_valid_i) state <= WB_CYCLE;
                WB_CYCLE: if (wb_ack_i) state <= WB_DONE;
                default:  state <= WB_IDLE;     // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid_i && mem_ready_o) begin
            adr_q <= mem_req_i.idx;
            dat_q <= mem_req_i.wdata;
            we_q  <= mem_req_i.write;
        end
        if (state == WB_CYCLE && wb_ack_i) begin
            rdata_q <= we_q ? '0 : wb_dat_i;    // writes return zero
        end
    end

    assign mem_ready_o = (state == WB_IDLE);
    assign mem_done_o  = (state == WB_DONE);
    assign mem_rdata_o = rdata_q;

    // cyc and stb drop on the cycle after ack
    assign wb_cyc_o = (state == WB_CYCLE);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = we_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;

    a_stb_held: assert property (@(posedge clk) disable iff (rst_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && wb_cyc_o && $stable(wb_adr_o))
        else $error("stb dropped or address moved before ack");

endmodule

`default_nettype wire

// ==== hw/data_sram.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mmio_config.svh"

module data_sram (
    input  wire logic                 clk,
    input  wire logic                 rst_i,
    input  wire logic                 wb_cyc_i,
    input  wire logic                 wb_stb_i,
    input  wire logic                 wb_we_i,
    input  wire mmio_pkg::word_idx_t  wb_adr_i,
    input  wire mmio_pkg::data_t      wb_dat_i,
    output mmio_pkg::data_t           wb_dat_o,
    output logic                      wb_ack_o
);
    import mmio_pkg::*;

    data_t mem [`MMIO_MEM_WORDS];
    data_t rdata_q;
    logic  ack_q;
    logic  req;

    assign req = wb_cyc_i && wb_stb_i;

    // single wait cycle, ack pulses once per strobe
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !ack_q) rdata_q <= mem[wb_adr_i];     // ready in ack cycle
        if (req && ack_q && wb_we_i) mem[wb_adr_i] <= wb_dat_i; // commit on ack
    end

    assign wb_dat_o = rdata_q;
    assign wb_ack_o = ack_q;

    a_ack_after_stb: assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_o |-> req && $past(req))
        else $error("ack without a held strobe");

endmodule

`default_nettype wire

// ==== hw/spi_cmd_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module spi_cmd_stage (
    input  wire logic                       clk,
    input  wire logic                       rst_i,
    // command register write, one-cycle pulse
    input  wire logic                       cmd_wr_i,
    input  wire periph_pkg::spi_cmd_reg_t   cmd_i,
    // parameter write, launches a transfer
    input  wire logic                       par_valid_i,
    input  wire mmio_pkg::data_t            par_i,
    output logic                            par_ready_o,
    // toward the external spi engine
    output logic                            spi_valid_o,
    output periph_pkg::spi_xfer_t           spi_xfer_o,
    input  wire logic                       spi_ready_i
);
    import periph_pkg::*;

    spi_cmd_reg_t cmd_q;
    spi_xfer_t    xfer_q;
    logic         spi_valid_q;

    assign par_ready_o = !spi_valid_q;  // one transfer in flight at most

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cmd_q       <= '0;
            spi_valid_q <= 1'b0;
        end else begin
            if (cmd_wr_i) cmd_q <= cmd_i;
            if (par_valid_i && par_ready_o) begin
                spi_valid_q <= 1'b1;
            end else if (spi_ready_i) begin
                spi_valid_q <= 1'b0;    // engine took it
            end
        end
    end

    // transfer built from the held command and the new parameters
    always_ff @(posedge clk) begin
        if (par_valid_i && par_ready_o) begin
            xfer_q <= '{cmd: cmd_q.cmd, cnt: cmd_q.cnt, params: par_i};
        end
    end

    assign spi_valid_o = spi_valid_q;
    assign spi_xfer_o  = xfer_q;

    a_xfer_stable: assert property (@(posedge clk) disable iff (rst_i)
        spi_valid_o && !spi_ready_i |=> spi_valid_o && $stable(spi_xfer_o))
        else $error("spi transfer changed under back-pressure");

endmodule

`default_nettype wire

// ==== hw/mmio_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mmio_top (
    input  wire logic                 clk,
    input  wire logic                 rst_i,
    input  wire logic                 req_valid_i,
    input  wire mmio_pkg::mmio_req_t  req_i,
    output logic                      req_ready_o,
    output logic                      rsp_valid_o,
    output mmio_pkg::mmio_rsp_t       rsp_o,
    input  wire logic                 rsp_ready_i,
    input  wire periph_pkg::i2c_xy_t  i2c_xy_i,
    input  wire logic                 i2c_done_i,
    output logic                      spi_valid_o,
    output periph_pkg::spi_xfer_t     spi_xfer_o,
    input  wire logic                 spi_ready_i
);
    import mmio_pkg::*;
    import periph_pkg::*;

    // router <-> wishbone master
    logic         mem_valid, mem_ready, mem_done;
    mem_req_t     mem_req;
    data_t        mem_rdata;
    // wishbone bus
    logic         wb_cyc, wb_stb, wb_we, wb_ack;
    word_idx_t    wb_adr;
    data_t        wb_dat_w, wb_dat_r;
    // router <-> spi stage
    logic         cmd_wr, par_valid, par_ready;
    spi_cmd_reg_t cmd;
    data_t        par;

    mmio_router i_mmio_router (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .i2c_xy_i    (i2c_xy_i),
        .i2c_done_i  (i2c_done_i),
        .mem_valid_o (mem_valid),
        .mem_req_o   (mem_req),
        .mem_ready_i (mem_ready),
        .mem_done_i  (mem_done),
        .mem_rdata_i (mem_rdata),
        .cmd_wr_o    (cmd_wr),
        .cmd_o       (cmd),
        .par_valid_o (par_valid),
        .par_o       (par),
        .par_ready_i (par_ready)
    );

    wb_master i_wb_master (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem_valid_i (mem_valid),
        .mem_req_i   (mem_req),
        .mem_ready_o (mem_ready),
        .mem_done_o  (mem_done),
        .mem_rdata_o (mem_rdata),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_dat_o    (wb_dat_w),
        .wb_dat_i    (wb_dat_r),
        .wb_ack_i    (wb_ack)
    );

    data_sram i_data_sram (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    spi_cmd_stage i_spi_cmd_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .cmd_wr_i    (cmd_wr),
        .cmd_i       (cmd),
        .par_valid_i (par_valid),
        .par_i       (par),
        .par_ready_o (par_ready),
        .spi_valid_o (spi_valid_o),
        .spi_xfer_o  (spi_xfer_o),
        .spi_ready_i (spi_ready_i)
    );

endmodule

`default_nettype wire

// ==== test/tb_mmio_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mmio_config.svh"

module tb_mmio_top;
    import mmio_pkg::*;
    import periph_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int N_MEM        = 16;   // memory writes, each read back once
    localparam int N_SPI        = 4;    // parameter writes
    localparam int N_I2C        = 6;
    localparam int N_UNMAP      = 5;

    logic      clk;
    logic      rst;
    logic      req_valid, req_ready;
    mmio_req_t req;
    logic      rsp_valid, rsp_ready;
    mmio_rsp_t rsp;
    i2c_xy_t   i2c_xy;
    logic      i2c_done;
    logic      spi_valid, spi_ready;
    spi_xfer_t spi_xfer;

    logic [31:0] data_lfsr  = 32'hec4c;   // addresses and data
    logic [31:0] stall_lfsr = 32'hec4c;   // ready toggling, own stream

    // scoreboard
    data_t        shadow [`MMIO_MEM_WORDS];
    data_t        exp_q [$];              // expected rdata, request order
    data_t        exp_head;               // front of exp_q
    int           exp_count;
    spi_cmd_reg_t last_cmd;
    spi_xfer_t    exp_xfer;
    logic         spi_pending;            // parameter write not yet taken by the engine
    int           spi_count   = 0;
    word_idx_t    written_q [$];          // words holding known data

    int error_count = 0;
    int passed      = 0;
    int failed      = 0;
    int req_issued  = 0;

    mmio_top i_mmio_top (
        .clk         (clk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .rsp_ready_i (rsp_ready),
        .i2c_xy_i    (i2c_xy),
        .i2c_done_i  (i2c_done),
        .spi_valid_o (spi_valid),
        .spi_xfer_o  (spi_xfer),
        .spi_ready_i (spi_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], data_lfsr[0]};
            data_lfsr = lfsr_next(data_lfsr);
        end
        return v;
    endfunction

    // random back-pressure on both ready inputs
    initial begin : ready_stall
        rsp_ready = 1'b0;
        spi_ready = 1'b0;
        forever begin
            @(posedge clk);
            rsp_ready <= stall_lfsr[0];
            stall_lfsr = lfsr_next(stall_lfsr);
            spi_ready <= stall_lfsr[0];
            stall_lfsr = lfsr_next(stall_lfsr);
        end
    end

    // reference model, updated on every handshake
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            last_cmd    = '0;
            spi_pending = 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                if (req.addr < `MMIO_MEM_LIMIT) begin
                    if (req.write) shadow[req.addr[10:2]] = req.wdata;
                    exp_q.push_back(req.write ? '0 : shadow[req.addr[10:2]]);
                end else if (req.write && req.addr == `MMIO_SPI_CMD_ADDR) begin
                    last_cmd = '{cmd: req.wdata[7:0], cnt: req.wdata[11:8]};
                    exp_q.push_back('0);
                end else if (req.write && req.addr == `MMIO_SPI_PARAM_ADDR) begin
                    exp_xfer    = '{cmd: last_cmd.cmd, cnt: last_cmd.cnt, params: req.wdata};
                    spi_pending = 1'b1;
                    exp_q.push_back('0);
                end else if (!req.write && req.addr == `MMIO_I2C_ADDR && i2c_done) begin
                    exp_q.push_back(i2c_xy);
                end else begin
                    exp_q.push_back(req.write ? '0 : `MMIO_BAD_DATA);  // unmapped or not ready
                end
            end
            if (rsp_valid && rsp_ready && exp_q.size() != 0) void'(exp_q.pop_front());
            if (spi_valid && spi_ready) begin
                spi_pending = 1'b0;
                spi_count++;
            end
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : '0;
    end

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !rsp_valid && !spi_valid && req_ready)
        else begin
            error_count++;
            $display("outputs were not idle on the first cycle after reset, at %0t", $time);
        end

    a_rsp_expected: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> exp_count > 0)
        else begin
            error_count++;
            $display("a response arrived with no request outstanding, at %0t", $time);
        end

    a_rsp_data: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp.rdata == exp_head)
        else begin
            error_count++;
            $display("ERR %0t: response data %h, expected %h",
                     $time, $sampled(rsp.rdata), $sampled(exp_head));
        end

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            error_count++;
            $display("response dropped or changed while stalled, at %0t", $time);
        end

    a_spi_expected: assert property (@(posedge clk) disable iff (rst)
        spi_valid && spi_ready |-> spi_pending)
        else begin
            error_count++;
            $display("an extra SPI transfer was taken by the engine, at %0t", $time);
        end

    a_spi_data: assert property (@(posedge clk) disable iff (rst)
        spi_valid && spi_ready |-> spi_xfer == exp_xfer)
        else begin
            error_count++;
            $display("ERR %0t: spi transfer %h, expected %h",
                     $time, $sampled(spi_xfer), $sampled(exp_xfer));
        end

    a_spi_hold: assert property (@(posedge clk) disable iff (rst)
        spi_valid && !spi_ready |=> spi_valid && $stable(spi_xfer))
        else begin
            error_count++;
            $display("SPI transfer dropped or changed while stalled, at %0t", $time);
        end

    a_spi_blocks_req: assert property (@(posedge clk) disable iff (rst)
        spi_valid |-> !req_ready)
        else begin
            error_count++;
            $display("a request was offered ready while an SPI transfer waited, at %0t", $time);
        end

    a_spi_before_rsp: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> !spi_pending)
        else begin
            error_count++;
            $display("parameter write answered before its transfer was taken, at %0t", $time);
        end

    // waits for the handshake edge, valid dropped right after
    task automatic send_req(input addr_t addr, input data_t wdata, input logic write);
        req_valid <= 1'b1;
        req       <= '{addr: addr, wdata: wdata, write: write};
        req_issued++;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
    endtask

    task automatic drain();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0 || spi_pending);
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        repeat (2) @(posedge clk);   // assertion actions of the last edges settle
        if (error_count == errs_at_start) begin
            passed++;
            $display("test %-9s passed", name);
        end else begin
            failed++;
            $display("test %-9s failed, %0d errors", name, error_count - errs_at_start);
        end
    endtask

    task automatic mem_test();
        word_idx_t idx;
        word_idx_t order [$];
        word_idx_t t;
        int        j;
        for (int i = 0; i < N_MEM; i++) begin
            idx = word_idx_t'(rand_bits(9));
            send_req(addr_t'({idx, 2'b00}), rand_bits(32), 1'b1);
            order.push_back(idx);
            written_q.push_back(idx);
        end
        for (int i = N_MEM - 1; i > 0; i--) begin   // shuffle the read order
            j        = rand_bits(8) % (i + 1);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[k]) send_req(addr_t'({order[k], 2'b00}), '0, 1'b0);
        drain();
    endtask

    task automatic spi_test();
        int n_before;
        n_before = spi_count;
        for (int i = 0; i < N_SPI; i++) begin
            send_req(`MMIO_SPI_CMD_ADDR, rand_bits(32), 1'b1);
            if (i == 1) send_req(`MMIO_SPI_CMD_ADDR, rand_bits(32), 1'b1);  // last one counts
            send_req(`MMIO_SPI_PARAM_ADDR, rand_bits(32), 1'b1);
        end
        send_req(`MMIO_SPI_PARAM_ADDR, '0, 1'b0);   // read, no transfer
        drain();
        a_spi_count: assert (spi_count - n_before == N_SPI)
            else begin
                error_count++;
                $display("ERR %0t: %0d spi transfers, expected %0d",
                         $time, spi_count - n_before, N_SPI);
            end
    endtask

    task automatic i2c_test();
        for (int i = 0; i < N_I2C; i++) begin
            i2c_xy   <= rand_bits(32);
            i2c_done <= i[0];          // done and not done alternate
            send_req(`MMIO_I2C_ADDR, '0, 1'b0);
        end
        send_req(`MMIO_I2C_ADDR, rand_bits(32), 1'b1);   // write, answered with zero
        drain();
        i2c_done <= 1'b0;
    endtask

    task automatic unmapped_test();
        word_idx_t idx;
        send_req(`MMIO_MEM_LIMIT, '0, 1'b0);   // first address past memory
        for (int i = 0; i < N_UNMAP; i++) begin
            send_req(rand_bits(32) | `MMIO_MEM_LIMIT, '0, 1'b0);
            idx = written_q[rand_bits(8) % written_q.size()];
            // same low bits as a written word, must not reach it
            send_req(`MMIO_MEM_LIMIT + addr_t'({idx, 2'b00}), rand_bits(32), 1'b1);
            send_req(addr_t'({idx, 2'b00}), '0, 1'b0);
        end
        drain();
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < RESET_CYCLES + 200 * (req_issued + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the DUT made no progress for too long, after %0d cycles", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int e0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        i2c_xy    = '0;
        i2c_done  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        e0 = error_count;
        finish_test("reset", e0);
        e0 = error_count;
        mem_test();
        finish_test("memory", e0);
        e0 = error_count;
        spi_test();
        finish_test("spi", e0);
        e0 = error_count;
        i2c_test();
        finish_test("i2c", e0);
        e0 = error_count;
        unmapped_test();
        finish_test("unmapped", e0);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, error_count);
        if (failed == 0 && error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hw/mmio_pkg.sv
hw/periph_pkg.sv
hw/mmio_router.sv
hw/wb_master.sv
hw/data_sram.sv
hw/spi_cmd_stage.sv
hw/mmio_top.sv
test/tb_mmio_top.sv
